// ==== compile.f ====
+incdir+verilog
verilog/AesPkg.sv
verilog/ExpandKey.sv
verilog/InitialRound.sv
verilog/CipherRound.sv
verilog/FinalRound.sv
verilog/AesEncryptPipe.sv
dv/AesEncryptPipe_assert.sv
dv/AesEncryptPipe_tb.sv

// ==== dv/AesEncryptPipe_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~
// AesEncryptPipe_tb: clock, reset, random stimulus, AES-128 reference
// model, scoreboard queue, compare tasks and watchdog
//~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

`include "aes_cfg.svh"

module AesEncryptPipe_tb;

    import AesPkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int STREAM_LEN = 200;
    localparam int GAP_CYCLES = 150;
    localparam int RELOAD_LEN = 64;
    localparam int RESET_LEN = 30;
    localparam int AFTER_RESET_LEN = 40;
    localparam int BLOCK_CYCLES = 1 + STREAM_LEN + GAP_CYCLES + RELOAD_LEN + RESET_LEN
        + 20 + AFTER_RESET_LEN;
    localparam int WATCHDOG_CYCLES = BLOCK_CYCLES + 5 * (`AES_LATENCY + 4) + 100;

    logic   clk = 1'b0;
    logic   rstN;
    logic   keyLoad;
    key_t   key;
    logic   inValid;
    state_t plainText;
    logic   outValid;
    state_t cipherText;

    integer seed = 32'hcd33_88e6;
    byte_t  sb [0:255];
    key_t   curKey;
    state_t expQ [$];
    string  testName;
    int     sentCount;
    int     outCount;

    AesEncryptPipe DUT
    (
        .clk        (clk),
        .rstN       (rstN),
        .keyLoad    (keyLoad),
        .key        (key),
        .inValid    (inValid),
        .plainText  (plainText),
        .outValid   (outValid),
        .cipherText (cipherText)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // GF(2^8) product by shift and add
    function automatic byte_t gmul(input byte_t a, input byte_t b);
        byte_t p;
        byte_t x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
            begin
                p = p ^ x;
            end
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // S-box from the field inverse followed by the affine map
    task automatic buildSbox();
        byte_t inv;
        for (int x = 0; x < 256; x++)
        begin
            inv = 8'h00;
            for (int y = 1; y < 256; y++)
            begin
                if (gmul(byte_t'(x), byte_t'(y)) == 8'h01)
                begin
                    inv = byte_t'(y);
                end
            end
            sb[x] = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
        end
    endtask

    function automatic state_t encryptBlock(input key_t k, input state_t pt);
        word_t  w [0:43];
        word_t  t;
        byte_t  rc;
        state_t s;
        state_t u;
        rc = 8'h01;
        for (int i = 0; i < 44; i++)
        begin
            if (i < 4)
            begin
                w[i] = k[127 - 32 * i -: 32];
            end
            else
            begin
                t = w[i-1];
                if (i % 4 == 0)
                begin
                    t = {sb[t[1]] ^ rc, sb[t[2]], sb[t[3]], sb[t[0]]};
                    rc = gmul(rc, 8'h02);
                end
                w[i] = w[i-4] ^ t;
            end
        end
        for (int c = 0; c < 4; c++)
        begin
            s[c] = pt[c] ^ w[c];
        end
        for (int r = 1; r <= `AES_NUM_ROUNDS; r++)
        begin
            // substitute and shift in one pass, row j moves j columns left
            for (int c = 0; c < 4; c++)
            begin
                for (int j = 0; j < 4; j++)
                begin
                    u[c][j] = sb[s[(c + j) % 4][j]];
                end
            end
            for (int c = 0; c < 4; c++)
            begin
                if (r < `AES_NUM_ROUNDS)
                begin
                    s[c][0] = gmul(u[c][0], 8'h02) ^ gmul(u[c][1], 8'h03) ^ u[c][2] ^ u[c][3];
                    s[c][1] = u[c][0] ^ gmul(u[c][1], 8'h02) ^ gmul(u[c][2], 8'h03) ^ u[c][3];
                    s[c][2] = u[c][0] ^ u[c][1] ^ gmul(u[c][2], 8'h02) ^ gmul(u[c][3], 8'h03);
                    s[c][3] = gmul(u[c][0], 8'h03) ^ u[c][1] ^ u[c][2] ^ gmul(u[c][3], 8'h02);
                end
                else
                begin
                    s[c] = u[c];
                end
                s[c] = s[c] ^ w[4 * r + c];
            end
        end
        return s;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkBlock(input string name, input state_t exp, input state_t act);
        if (act !== exp)
        begin
            abortRun($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        if (act != exp)
        begin
            abortRun($sformatf("mismatch in %s: expected %0d results, actual %0d",
                name, exp, act));
        end
    endtask

    function automatic state_t randomState();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic sendBlock(input state_t pt, input state_t exp);
        @(posedge clk);
        #1;
        inValid = 1'b1;
        plainText = pt;
        expQ.push_back(exp);
        sentCount++;
    endtask

    task automatic sendRandom();
        state_t pt;
        pt = randomState();
        sendBlock(pt, encryptBlock(curKey, pt));
    endtask

    task automatic sendIdle();
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    // the last accepted block leaves the pipeline a fixed latency after it entered
    task automatic drainPipe();
        sendIdle();
        repeat (`AES_LATENCY + 2) @(posedge clk);
        #1;
        checkCount(testName, sentCount, outCount);
    endtask

    task automatic loadKey(input key_t k);
        @(posedge clk);
        #1;
        keyLoad = 1'b1;
        key = k;
        curKey = k;
        @(posedge clk);
        #1;
        keyLoad = 1'b0;
    endtask

    // blocks in flight are flushed, so the scoreboard starts over
    task automatic applyReset();
        @(posedge clk);
        #1;
        rstN = 1'b0;
        inValid = 1'b0;
        expQ.delete();
        sentCount = 0;
        outCount = 0;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;
    endtask

    always @(posedge clk)
    begin
        if (DUT.timingChecks.failCount != 0)
        begin
            abortRun("a bound timing or protocol assertion failed");
        end
        else if (rstN && outValid)
        begin
            if (expQ.size() == 0)
            begin
                abortRun($sformatf("%s: outValid was high with no block in flight", testName));
            end
            else
            begin
                checkBlock(testName, expQ.pop_front(), cipherText);
                outCount++;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abortRun("watchdog timeout, the tests did not finish in time");
    end

    initial
    begin
        rstN = 1'b0;
        keyLoad = 1'b0;
        key = '0;
        inValid = 1'b0;
        plainText = '0;
        curKey = '0;
        sentCount = 0;
        outCount = 0;
        testName = "reset";
        buildSbox();
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;

        // FIPS-197 appendix C.1 example vector
        testName = "known answer";
        loadKey(128'h000102030405060708090a0b0c0d0e0f);
        sendBlock(128'h00112233445566778899aabbccddeeff, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        drainPipe();

        testName = "back-to-back stream";
        loadKey(key_t'(randomState()));
        repeat (STREAM_LEN) sendRandom();
        drainPipe();

        testName = "gapped input";
        repeat (GAP_CYCLES)
        begin
            if ($random(seed) & 1)
            begin
                sendRandom();
            end
            else
            begin
                sendIdle();
            end
        end
        drainPipe();

        testName = "key reload";
        loadKey(key_t'(randomState()));
        repeat (RELOAD_LEN) sendRandom();
        drainPipe();

        testName = "reset mid-stream";
        repeat (RESET_LEN) sendRandom();
        applyReset();
        repeat (20) sendIdle();
        repeat (AFTER_RESET_LEN) sendRandom();
        drainPipe();

        if (DUT.timingChecks.failCount == 0)
        begin
            $display("** PASS **");
            $finish;
        end
        else
        begin
            abortRun("bound assertions reported failures");
        end
    end

endmodule

`default_nettype wire

// ==== dv/AesEncryptPipe_assert.sv ====
//~~~~~~~~~~~~~~~~~~~~
// AesEncryptPipe_assert: latency, reset and key load assertions
//~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

`include "aes_cfg.svh"

module AesEncryptPipe_assert
(
    input logic                       clk,
    input logic                       rstN,
    input logic                       keyLoad,
    input logic                       inValid,
    input logic                       outValid,
    input logic [0:`AES_NUM_ROUNDS-1] stageValid
);

    int failCount = 0;

    // every accepted block leaves exactly one latency later
    latencyHolds: assert property (@(posedge clk) disable iff (!rstN)
        inValid |-> ##(`AES_LATENCY) outValid)
    else
    begin
        failCount++;
        $error("accepted block did not come out after the pipeline latency");
    end

    noExtraOutput: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> $past(inValid, `AES_LATENCY))
    else
    begin
        failCount++;
        $error("outValid without a matching accepted block");
    end

    resetClears: assert property (@(posedge clk) !rstN |=> !outValid)
    else
    begin
        failCount++;
        $error("outValid not low after reset");
    end

    // the key may only change while the pipeline is empty
    keyLoadIdle: assert property (@(posedge clk) disable iff (!rstN)
        keyLoad |-> (stageValid == '0))
    else
    begin
        failCount++;
        $error("keyLoad while blocks are in flight");
    end

endmodule

bind AesEncryptPipe AesEncryptPipe_assert timingChecks
(
    .clk        (clk),
    .rstN       (rstN),
    .keyLoad    (keyLoad),
    .inValid    (inValid),
    .outValid   (outValid),
    .stageValid (stageValid)
);

`default_nettype wire

// ==== verilog/AesEncryptPipe.sv ====
//~~~~~~~~~~~~~~~~~~~~
// AesEncryptPipe: key register, key schedule
// and the eleven-stage AES-128 encryption pipeline
//~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

`include "aes_cfg.svh"

module AesEncryptPipe
(
    input  logic            clk,
    input  logic            rstN,
    input  logic            keyLoad,
    input  AesPkg::key_t    key,
    input  logic            inValid,
    input  AesPkg::state_t  plainText,
    output logic            outValid,
    output AesPkg::state_t  cipherText
);

    import AesPkg::*;

    key_t       keyReg;
    roundKeys_t roundKeys;

    // stage 0 is the initial round, stages 1 to 9 are the middle rounds
    state_t stageState [0:`AES_NUM_ROUNDS-1];
    logic   [0:`AES_NUM_ROUNDS-1] stageValid;

    // the key is only reloaded while the pipeline is empty
    always_ff @(posedge clk)
    begin
        if (keyLoad)
        begin
            keyReg <= key;
        end
    end

    ExpandKey expandKey
    (
        .key       (keyReg),
        .roundKeys (roundKeys)
    );

    InitialRound initialRound
    (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .plainText (plainText),
        .roundKey  (roundKeys[0]),
        .stateOut  (stageState[0]),
        .validOut  (stageValid[0])
    );

    for (genvar g = 1; g < `AES_NUM_ROUNDS; g++)
    begin : genRound
        CipherRound cipherRound
        (
            .clk      (clk),
            .rstN     (rstN),
            .validIn  (stageValid[g-1]),
            .stateIn  (stageState[g-1]),
            .roundKey (roundKeys[g]),
            .stateOut (stageState[g]),
            .validOut (stageValid[g])
        );
    end

    FinalRound finalRound
    (
        .clk        (clk),
        .rstN       (rstN),
        .validIn    (stageValid[`AES_NUM_ROUNDS-1]),
        .stateIn    (stageState[`AES_NUM_ROUNDS-1]),
        .roundKey   (roundKeys[`AES_NUM_ROUNDS]),
        .cipherText (cipherText),
        .outValid   (outValid)
    );

endmodule

`default_nettype wire

// ==== verilog/FinalRound.sv ====
//~~~~~~~~~~~~~~~~~~~~
// FinalRound: last AES round without MixColumns
//~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

module FinalRound
(
    input  logic            clk,
    input  logic            rstN,
    input  logic            validIn,
    input  AesPkg::state_t  stateIn,
    input  AesPkg::state_t  roundKey,
    output AesPkg::state_t  cipherText,
    output logic            outValid
);

    import AesPkg::*;

    state_t lastState;

    assign lastState = shiftRows(subBytes(stateIn)) ^ roundKey;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            outValid <= 1'b0;
        end
        else
        begin
            outValid <= validIn;
        end
    end

    // ciphertext holds between results, outValid marks the new one
    always_ff @(posedge clk)
    begin
        if (validIn)
        begin
            cipherText <= lastState;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/CipherRound.sv ====
//~~~~~~~~~~~~~~~~~~~~
// CipherRound: one registered full AES round
//~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

module CipherRound
(
    input  logic            clk,
    input  logic            rstN,
    input  logic            validIn,
    input  AesPkg::state_t  stateIn,
    input  AesPkg::state_t  roundKey,
    output AesPkg::state_t  stateOut,
    output logic            validOut
);

    import AesPkg::*;

    state_t shifted;
    state_t mixed;
    state_t nextState;

    // column times the fixed MixColumns matrix {02 03 01 01}
    function automatic word_t mixColumn(input word_t a);
        word_t m;
        m[0] = xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
        m[1] = a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3];
        m[2] = a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3];
        m[3] = xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3]);
        return m;
    endfunction

    always_comb
    begin
        shifted = shiftRows(subBytes(stateIn));
        for (int c = 0; c < 4; c++)
        begin
            mixed[c] = mixColumn(shifted[c]);
        end
        nextState = mixed ^ roundKey;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            validOut <= 1'b0;
        end
        else
        begin
            validOut <= validIn;
        end
    end

    // idle cycles leave the last state in place
    always_ff @(posedge clk)
    begin
        if (validIn)
        begin
            stateOut <= nextState;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/InitialRound.sv ====
//~~~~~~~~~~~~~~~~~~~~
// InitialRound: pipeline entry, first AddRoundKey
//~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

module InitialRound
(
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    input  AesPkg::state_t  plainText,
    input  AesPkg::state_t  roundKey,
    output AesPkg::state_t  stateOut,
    output logic            validOut
);

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            validOut <= 1'b0;
        end
        else
        begin
            validOut <= inValid;
        end
    end

    // the state register only loads on an accepted block
    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            stateOut <= plainText ^ roundKey;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ExpandKey.sv ====
//~~~~~~~~~~~~~~~~~~~~
// ExpandKey: combinational AES-128 key schedule
//~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

`include "aes_cfg.svh"

module ExpandKey
(
    input  AesPkg::key_t       key,
    output AesPkg::roundKeys_t roundKeys
);

    import AesPkg::*;

    // round constants, only the leading byte of the word is non-zero
    localparam byte_t RCON [1:`AES_NUM_ROUNDS] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    always_comb
    begin
        // round key 0 is the cipher key itself
        roundKeys[0] = state_t'(key);

        for (int j = 1; j <= `AES_NUM_ROUNDS; j++)
        begin
            word_t prevLast;
            word_t mixed;

            prevLast = roundKeys[j-1][3];

            // the first column goes through rotate, substitute and the round constant
            mixed = subWord(rotWord(prevLast)) ^ word_t'({RCON[j], 24'h000000});
            roundKeys[j][0] = roundKeys[j-1][0] ^ mixed;

            // each remaining column chains from the one just produced
            for (int i = 1; i < 4; i++)
            begin
                roundKeys[j][i] = roundKeys[j][i-1] ^ roundKeys[j-1][i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/AesPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~
// AesPkg: AES byte, word, state and round key types
// S-box table and byte/word/state helper functions
//~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "aes_cfg.svh"

package AesPkg;

    typedef logic [7:0] byte_t;

    // one state column, byte 0 sits in the top bits as in FIPS-197
    typedef byte_t [0:3] word_t;
    typedef word_t [0:3] state_t;

    typedef logic [`AES_KEY_BITS-1:0] key_t;
    typedef state_t [0:`AES_NUM_ROUNDS] roundKeys_t;

    // forward S-box, entry 0 in the most significant byte
    localparam byte_t [0:255] sbox = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic word_t subWord(input word_t w);
        word_t s;
        for (int i = 0; i < 4; i++)
        begin
            s[i] = sbox[w[i]];
        end
        return s;
    endfunction

    // cyclic left rotation by one byte, used by the key schedule
    function automatic word_t rotWord(input word_t w);
        return {w[1:3], w[0]};
    endfunction

    // multiply by x in GF(2^8) modulo the AES polynomial
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic state_t subBytes(input state_t s);
        state_t r;
        for (int c = 0; c < 4; c++)
        begin
            r[c] = subWord(s[c]);
        end
        return r;
    endfunction

    // row n moves n columns to the left
    function automatic state_t shiftRows(input state_t s);
        state_t r;
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
            begin
                r[c][row] = s[(c + row) % 4][row];
            end
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/aes_cfg.svh ====
//~~~~~~~~~~~~~~~~~~~~
// AES-128 key width, round count and pipeline latency
//~~~~~~~~~~~~~~~~~~~~

`ifndef AES_CFG_SVH
`define AES_CFG_SVH

`define AES_KEY_BITS   128
`define AES_NUM_ROUNDS 10
`define AES_LATENCY    (`AES_NUM_ROUNDS + 1)

`endif
